/* sim.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/fwd_if.sv
verilog/decode_stage.sv
verilog/data_select_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/core.sv
verification/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f sim.f --top-module core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vcore_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

/* verification/core_tb.sv */
`timescale 1ns/1ns

module core_tb;
    import core_pkg::*;

    localparam int PROG_LEN = 48;
    localparam int MAX_CYCLES = 3000;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] imem_addr;
    logic [31:0] imem_inst;
    logic        dmem_valid;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_ready = 1'b0;
    logic [31:0] dmem_rdata = 32'h0;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        exit;

    logic [31:0] lfsr = 32'hbba3;
    logic [31:0] rom [64];
    logic [31:0] dmem_array [64];
    logic [31:0] model_mem [64];
    logic [31:0] model_regs [8];
    opcode_e     f_op [64];
    int          f_rd [64];
    int          f_rs1 [64];
    int          f_rs2 [64];
    int          f_imm [64];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_val [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    int          errors = 0;
    int          ret_count = 0;
    int          st_count = 0;
    int          cycles = 0;
    logic        dm_busy = 1'b0;
    int          dm_delay = 0;

    always #4 clk = ~clk;

    core u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr    (imem_addr),
        .imem_inst    (imem_inst),
        .dmem_valid   (dmem_valid),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_ready   (dmem_ready),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .exit         (exit)
    );

    // words past the program in the instruction rom read as zero
    assign imem_inst = (imem_addr < 32'd256) ? rom[imem_addr[7:2]] : 32'h0;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input int addr);
        return ((addr + 1) * 32'h9e37_79b9) ^ 32'h0bad_0000;
    endfunction

    function automatic logic [31:0] encode(input opcode_e op, input int rd, input int rs1,
                                           input int rs2, input int imm);
        logic [31:0] v;
        v = 32'h0;
        case (op)
            OP_ADD: v = {7'h00, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
            OP_SUB: v = {7'h20, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
            OP_AND: v = {7'h00, rs2[4:0], rs1[4:0], 3'b111, rd[4:0], 7'b0110011};
            OP_OR: v = {7'h00, rs2[4:0], rs1[4:0], 3'b110, rd[4:0], 7'b0110011};
            OP_XOR: v = {7'h00, rs2[4:0], rs1[4:0], 3'b100, rd[4:0], 7'b0110011};
            OP_ADDI: v = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
            OP_LW: v = {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
            OP_SW: v = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
            OP_BEQ: v = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11],
                         7'b1100011};
            OP_BNE: v = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b001, imm[4:1], imm[11],
                         7'b1100011};
            OP_JAL: v = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
            OP_ECALL: v = 32'h0000_0073;
            default: v = 32'h0;
        endcase
        return v;
    endfunction

    task automatic set_slot(input int idx, input opcode_e op, input int rd, input int rs1,
                            input int rs2, input int imm);
        f_op[idx[5:0]] = op;
        f_rd[idx[5:0]] = rd;
        f_rs1[idx[5:0]] = rs1;
        f_rs2[idx[5:0]] = rs2;
        f_imm[idx[5:0]] = imm;
        rom[idx[5:0]] = encode(op, rd, rs1, rs2, imm);
    endtask

    task automatic build_program();
        opcode_e     op;
        logic [31:0] sel;
        int          rd;
        int          rs1;
        int          rs2;
        int          imm;
        int          off;
        for (int i = 0; i < 64; i++) begin
            rom[i[5:0]] = 32'h0;
            dmem_array[i[5:0]] = fill_word(i);
            model_mem[i[5:0]] = fill_word(i);
        end
        for (int i = 0; i < 8; i++) begin
            model_regs[i[2:0]] = 32'h0;
        end
        // x1..x7 start from known values
        for (int i = 0; i < 7; i++) begin
            sel = draw_bits(12);
            set_slot(i, OP_ADDI, i + 1, 0, 0, {{20{sel[11]}}, sel[11:0]});
        end
        // store, load, then use of the load right after it
        sel = draw_bits(6);
        set_slot(7, OP_SW, 0, 0, 1, sel * 4);
        set_slot(8, OP_LW, 2, 0, 0, sel * 4);
        set_slot(9, OP_ADD, 3, 2, 2, 0);
        set_slot(10, OP_SUB, 4, 3, 1, 0);
        for (int i = 11; i < PROG_LEN - 1; i++) begin
            case (draw_bits(3))
                0: op = OP_ADD;
                1: op = OP_SUB;
                2: op = OP_AND;
                3: op = OP_OR;
                4: op = OP_XOR;
                5: op = OP_ADDI;
                6: op = draw_bits(1) ? OP_SW : OP_LW;
                default: begin
                    sel = draw_bits(2);
                    op = (sel == 0) ? OP_BEQ : (sel == 1) ? OP_BNE : OP_JAL;
                end
            endcase
            rd = draw_bits(3) % 7 + 1;
            rs1 = draw_bits(3);
            rs2 = draw_bits(3);
            imm = 0;
            if (op == OP_ADDI) begin
                sel = draw_bits(12);
                imm = {{20{sel[11]}}, sel[11:0]};
            end else if (op == OP_LW || op == OP_SW) begin
                rs1 = 0;
                imm = draw_bits(6) * 4;
            end else if (op == OP_BEQ || op == OP_BNE || op == OP_JAL) begin
                // forward only, never past the ecall
                off = 1 + draw_bits(2);
                if (off > PROG_LEN - 1 - i) begin
                    off = PROG_LEN - 1 - i;
                end
                imm = off * 4;
            end
            set_slot(i, op, rd, rs1, rs2, imm);
        end
        set_slot(PROG_LEN - 1, OP_ECALL, 0, 0, 0, 0);
    endtask

    // architectural run of the program, in order
    task automatic run_model();
        logic [5:0]  pc_i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] wv;
        logic        wr;
        pc_i = 6'd0;
        while (f_op[pc_i] != OP_ECALL) begin
            a = model_regs[f_rs1[pc_i][2:0]];
            b = model_regs[f_rs2[pc_i][2:0]];
            wr = 1'b1;
            wv = 32'h0;
            case (f_op[pc_i])
                OP_ADD: wv = a + b;
                OP_SUB: wv = a - b;
                OP_AND: wv = a & b;
                OP_OR: wv = a | b;
                OP_XOR: wv = a ^ b;
                OP_ADDI: wv = a + f_imm[pc_i];
                OP_LW: wv = model_mem[f_imm[pc_i][7:2]];
                OP_JAL: wv = {24'd0, pc_i, 2'b00} + 32'd4;
                OP_SW: begin
                    wr = 1'b0;
                    model_mem[f_imm[pc_i][7:2]] = b;
                    exp_st_addr.push_back(f_imm[pc_i]);
                    exp_st_data.push_back(b);
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                model_regs[f_rd[pc_i][2:0]] = wv;
                exp_rd.push_back(f_rd[pc_i]);
                exp_val.push_back(wv);
            end
            if (f_op[pc_i] == OP_JAL || (f_op[pc_i] == OP_BEQ && a == b) ||
                (f_op[pc_i] == OP_BNE && a != b)) begin
                pc_i = pc_i + f_imm[pc_i][7:2];
            end else begin
                pc_i = pc_i + 6'd1;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ready after 0 to 3 cycles and the transfer completes on the next rising edge
    task automatic serve_dmem();
        dmem_ready = 1'b0;
        if (dmem_valid) begin
            if (!dm_busy) begin
                dm_busy = 1'b1;
                dm_delay = draw_bits(2);
            end
            if (dm_delay == 0) begin
                dm_busy = 1'b0;
                dmem_ready = 1'b1;
                if (dmem_addr >= 32'd256 || dmem_addr[1:0] != 2'b00) begin
                    $display("data access at address %h is outside the test memory", dmem_addr);
                    errors++;
                end else if (dmem_we) begin
                    if (st_count < exp_st_addr.size()) begin
                        check_value("dmem_addr", dmem_addr, exp_st_addr[st_count]);
                        check_value("dmem_wdata", dmem_wdata, exp_st_data[st_count]);
                    end else begin
                        $display("store to %h came after all expected stores", dmem_addr);
                        errors++;
                    end
                    dmem_array[dmem_addr[7:2]] = dmem_wdata;
                    st_count++;
                end else begin
                    dmem_rdata = dmem_array[dmem_addr[7:2]];
                end
            end else begin
                dm_delay--;
            end
        end
    endtask

    task automatic check_retire();
        if (retire_valid) begin
            if (ret_count < exp_rd.size()) begin
                check_value("retire_rd", {27'd0, retire_rd}, exp_rd[ret_count]);
                check_value("retire_data", retire_data, exp_val[ret_count]);
            end else begin
                $display("write to x%0d came after all expected register writes", retire_rd);
                errors++;
            end
            ret_count++;
        end
    endtask

    initial begin
        build_program();
        run_model();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_value("exit", {31'd0, exit}, 32'd0);
        check_value("dmem_valid", {31'd0, dmem_valid}, 32'd0);
        check_value("retire_valid", {31'd0, retire_valid}, 32'd0);
        check_value("imem_addr", imem_addr, 32'd0);
        while (!exit && cycles < MAX_CYCLES) begin
            @(negedge clk);
            serve_dmem();
            check_retire();
            cycles++;
        end
        if (!exit) begin
            $display("timeout: exit did not rise within %0d cycles", MAX_CYCLES);
            errors++;
        end else begin
            check_value("retire_count", ret_count, exp_rd.size());
            check_value("store_count", st_count, exp_st_addr.size());
        end
        $display("errors %0d, retires %0d of %0d, stores %0d of %0d", errors, ret_count,
                 exp_rd.size(), st_count, exp_st_addr.size());
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/core.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module core (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic [`CORE_XLEN-1:0]          imem_addr,
    input  logic [`CORE_XLEN-1:0]          imem_inst,
    output logic                           dmem_valid,
    output logic                           dmem_we,
    output logic [`CORE_XLEN-1:0]          dmem_addr,
    output logic [`CORE_XLEN-1:0]          dmem_wdata,
    input  logic                           dmem_ready,
    input  logic [`CORE_XLEN-1:0]          dmem_rdata,
    output logic                           retire_valid,
    output logic [$clog2(`CORE_NREGS)-1:0] retire_rd,
    output logic [`CORE_XLEN-1:0]          retire_data,
    output logic                           exit
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0] pc;
    logic                  halted;

    logic                  id_valid;
    logic [`CORE_XLEN-1:0] id_pc;
    logic [`CORE_XLEN-1:0] id_inst;
    ctrl_t                 id_ctrl;

    logic                           ds_valid;
    logic [`CORE_XLEN-1:0]          ds_pc;
    ctrl_t                          ds_ctrl;
    logic [`CORE_XLEN-1:0]          ds_op_a;
    logic [`CORE_XLEN-1:0]          ds_op_b;
    logic [`CORE_XLEN-1:0]          ds_store_data;
    logic [$clog2(`CORE_NREGS)-1:0] rf_rs1_addr;
    logic [$clog2(`CORE_NREGS)-1:0] rf_rs2_addr;
    logic [`CORE_XLEN-1:0]          rf_rs1_data;
    logic [`CORE_XLEN-1:0]          rf_rs2_data;
    logic                           dh_stall;

    logic                  exe_valid;
    logic [`CORE_XLEN-1:0] exe_pc;
    ctrl_t                 exe_ctrl;
    logic [`CORE_XLEN-1:0] exe_op_a;
    logic [`CORE_XLEN-1:0] exe_op_b;
    logic [`CORE_XLEN-1:0] exe_rs2;
    logic [`CORE_XLEN-1:0] exe_alu_out;
    logic [`CORE_XLEN-1:0] exe_target;
    logic                  exe_taken;

    logic                  mem_valid;
    logic [`CORE_XLEN-1:0] mem_pc;
    ctrl_t                 mem_ctrl;
    logic [`CORE_XLEN-1:0] mem_alu_out;
    logic [`CORE_XLEN-1:0] mem_store_data;
    logic [`CORE_XLEN-1:0] mem_rdata;
    logic                  mem_hold;

    logic                  wb_valid;
    logic [`CORE_XLEN-1:0] wb_pc;
    ctrl_t                 wb_ctrl;
    logic [`CORE_XLEN-1:0] wb_alu_out;
    logic [`CORE_XLEN-1:0] wb_mem_rdata;

    logic exe_stall;
    logic ds_stall;
    logic id_stall;
    logic redirect;
    logic flush;

    fwd_if fw_exe ();
    fwd_if fw_mem ();
    fwd_if fw_wb ();

    // stall chain with writeback never holding
    assign exe_stall = exe_valid && mem_hold;
    assign ds_stall = ds_valid && (exe_stall || dh_stall);
    assign id_stall = id_valid && ds_stall;

    // not-taken prediction so any taken transfer redirects
    assign redirect = exe_valid && exe_taken;
    // ecall also squashes whatever was fetched behind it
    assign flush = redirect || (exe_valid && exe_ctrl.is_exit);
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_PC;
            halted <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= exe_target;
            end else if (!id_stall && !halted) begin
                pc <= pc + 4;
            end
            if (exe_valid && exe_ctrl.is_exit) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            ds_valid <= 1'b0;
            exe_valid <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            if (flush || halted) begin
                id_valid <= 1'b0;
            end else if (!id_stall) begin
                id_valid <= 1'b1;
            end
            if (flush) begin
                ds_valid <= 1'b0;
            end else if (!ds_stall) begin
                ds_valid <= id_valid;
            end
            // a held data select stage sends a bubble
            if (!exe_stall) begin
                exe_valid <= ds_valid && !ds_stall && !flush;
            end
            if (!mem_hold) begin
                mem_valid <= exe_valid;
            end
            wb_valid <= mem_valid && !mem_hold;
        end
    end

    always_ff @(posedge clk) begin
        if (!id_stall) begin
            id_pc <= pc;
            id_inst <= imem_inst;
        end
        if (!ds_stall) begin
            ds_pc <= id_pc;
            ds_ctrl <= id_ctrl;
        end
        if (!exe_stall) begin
            exe_pc <= ds_pc;
            exe_ctrl <= ds_ctrl;
            exe_op_a <= ds_op_a;
            exe_op_b <= ds_op_b;
            exe_rs2 <= ds_store_data;
        end
        if (!mem_hold) begin
            mem_pc <= exe_pc;
            mem_ctrl <= exe_ctrl;
            mem_alu_out <= exe_alu_out;
            mem_store_data <= exe_rs2;
        end
        wb_pc <= mem_pc;
        wb_ctrl <= mem_ctrl;
        wb_alu_out <= mem_alu_out;
        wb_mem_rdata <= mem_rdata;
    end

    // execute results are one cycle too late to forward
    assign fw_exe.valid = exe_valid && exe_ctrl.rf_wen;
    assign fw_exe.can_forward = 1'b0;
    assign fw_exe.addr = exe_ctrl.rd;
    assign fw_exe.wdata = exe_alu_out;

    // load data only shows up in writeback
    assign fw_mem.valid = mem_valid && mem_ctrl.rf_wen;
    assign fw_mem.can_forward = !mem_ctrl.mem_rd;
    assign fw_mem.addr = mem_ctrl.rd;
    assign fw_mem.wdata = (mem_ctrl.wb_sel == WB_PC4) ? mem_pc + 4 : mem_alu_out;

    decode_stage u_decode (
        .inst (id_inst),
        .ctrl (id_ctrl)
    );

    data_select_stage u_data_select (
        .ctrl        (ds_ctrl),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .rf_rs1_addr (rf_rs1_addr),
        .rf_rs2_addr (rf_rs2_addr),
        .fw_exe      (fw_exe.sink),
        .fw_mem      (fw_mem.sink),
        .fw_wb       (fw_wb.sink),
        .op_a        (ds_op_a),
        .op_b        (ds_op_b),
        .store_data  (ds_store_data),
        .dh_stall    (dh_stall)
    );

    execute_stage u_execute (
        .ctrl          (exe_ctrl),
        .pc            (exe_pc),
        .op_a          (exe_op_a),
        .op_b          (exe_op_b),
        .rs2_data      (exe_rs2),
        .alu_out       (exe_alu_out),
        .branch_taken  (exe_taken),
        .branch_target (exe_target)
    );

    memory_stage u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (mem_valid),
        .ctrl       (mem_ctrl),
        .alu_out    (mem_alu_out),
        .store_data (mem_store_data),
        .dmem_valid (dmem_valid),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata),
        .mem_rdata  (mem_rdata),
        .mem_stall  (mem_hold)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (wb_valid),
        .ctrl         (wb_ctrl),
        .pc           (wb_pc),
        .alu_out      (wb_alu_out),
        .mem_rdata    (wb_mem_rdata),
        .rs1_addr     (rf_rs1_addr),
        .rs2_addr     (rf_rs2_addr),
        .rs1_data     (rf_rs1_data),
        .rs2_data     (rf_rs2_data),
        .fw_wb        (fw_wb.source),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .exit         (exit)
    );

    // held stages keep their instruction until the stall clears
    assert property (@(posedge clk) disable iff (!rst_n)
        exe_stall |=> exe_valid && $stable({exe_pc, exe_ctrl, exe_op_a, exe_op_b, exe_rs2}));
    assert property (@(posedge clk) disable iff (!rst_n)
        ds_stall && !flush |=> ds_valid && $stable({ds_pc, ds_ctrl}));

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module writeback_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           valid,
    input  core_pkg::ctrl_t                ctrl,
    input  logic [`CORE_XLEN-1:0]          pc,
    input  logic [`CORE_XLEN-1:0]          alu_out,
    input  logic [`CORE_XLEN-1:0]          mem_rdata,
    input  logic [$clog2(`CORE_NREGS)-1:0] rs1_addr,
    input  logic [$clog2(`CORE_NREGS)-1:0] rs2_addr,
    output logic [`CORE_XLEN-1:0]          rs1_data,
    output logic [`CORE_XLEN-1:0]          rs2_data,
    fwd_if.source                          fw_wb,
    output logic                           retire_valid,
    output logic [$clog2(`CORE_NREGS)-1:0] retire_rd,
    output logic [`CORE_XLEN-1:0]          retire_data,
    output logic                           exit
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
    logic [`CORE_XLEN-1:0] wdata;
    logic                  wen;

    assign wen = valid && ctrl.rf_wen;

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM: wdata = mem_rdata;
            WB_PC4: wdata = pc + 4;
            default: wdata = alu_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[ctrl.rd] <= wdata;
        end
    end

    // x0 is never stored, so it reads as zero here
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    assign fw_wb.valid = wen;
    assign fw_wb.can_forward = 1'b1;
    assign fw_wb.addr = ctrl.rd;
    assign fw_wb.wdata = wdata;

    assign retire_valid = wen;
    assign retire_rd = ctrl.rd;
    assign retire_data = wdata;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exit <= 1'b0;
        end else if (valid && ctrl.is_exit) begin
            exit <= 1'b1;
        end
    end

    // decode must have dropped every x0 destination
    assert property (@(posedge clk) disable iff (!rst_n) wen |-> ctrl.rd != '0);

endmodule

/* verilog/memory_stage.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module memory_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid,
    input  core_pkg::ctrl_t       ctrl,
    input  logic [`CORE_XLEN-1:0] alu_out,
    input  logic [`CORE_XLEN-1:0] store_data,
    output logic                  dmem_valid,
    output logic                  dmem_we,
    output logic [`CORE_XLEN-1:0] dmem_addr,
    output logic [`CORE_XLEN-1:0] dmem_wdata,
    input  logic                  dmem_ready,
    input  logic [`CORE_XLEN-1:0] dmem_rdata,
    output logic [`CORE_XLEN-1:0] mem_rdata,
    output logic                  mem_stall
);

    logic pending;

    assign dmem_valid = valid && (ctrl.mem_rd || ctrl.mem_wr);
    assign dmem_we = ctrl.mem_wr;
    assign dmem_addr = alu_out;
    assign dmem_wdata = store_data;

    // load data is taken in the ready cycle
    assign mem_rdata = dmem_rdata;
    assign mem_stall = dmem_valid && !dmem_ready;

    // request was waiting on the last edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= mem_stall;
        end
    end

    // an outstanding request is neither dropped nor changed before ready
    assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> dmem_valid && $stable({dmem_we, dmem_addr, dmem_wdata}));

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module execute_stage (
    input  core_pkg::ctrl_t       ctrl,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic [`CORE_XLEN-1:0] op_a,
    input  logic [`CORE_XLEN-1:0] op_b,
    input  logic [`CORE_XLEN-1:0] rs2_data,
    output logic [`CORE_XLEN-1:0] alu_out,
    output logic                  branch_taken,
    output logic [`CORE_XLEN-1:0] branch_target
);
    import core_pkg::*;

    logic equal;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR: alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_PASS_B: alu_out = op_b;
            default: alu_out = op_b;
        endcase
    end

    // both branch operands arrive already forwarded
    assign equal = (op_a == rs2_data);
    assign branch_taken = ctrl.is_jal ||
                          (ctrl.is_branch && (equal != (ctrl.opcode == OP_BNE)));
    assign branch_target = pc + ctrl.imm;

endmodule

/* verilog/data_select_stage.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module data_select_stage (
    input  core_pkg::ctrl_t                ctrl,
    input  logic [`CORE_XLEN-1:0]          rf_rs1_data,
    input  logic [`CORE_XLEN-1:0]          rf_rs2_data,
    output logic [$clog2(`CORE_NREGS)-1:0] rf_rs1_addr,
    output logic [$clog2(`CORE_NREGS)-1:0] rf_rs2_addr,
    fwd_if.sink                            fw_exe,
    fwd_if.sink                            fw_mem,
    fwd_if.sink                            fw_wb,
    output logic [`CORE_XLEN-1:0]          op_a,
    output logic [`CORE_XLEN-1:0]          op_b,
    output logic [`CORE_XLEN-1:0]          store_data,
    output logic                           dh_stall
);

    logic [$clog2(`CORE_NREGS)-1:0] src [2];
    logic [`CORE_XLEN-1:0]          rf_val [2];
    logic [`CORE_XLEN-1:0]          fwd_val [2];
    logic                           hazard [2];

    assign rf_rs1_addr = ctrl.rs1;
    assign rf_rs2_addr = ctrl.rs2;
    assign src[0] = ctrl.rs1;
    assign src[1] = ctrl.rs2;
    assign rf_val[0] = rf_rs1_data;
    assign rf_val[1] = rf_rs2_data;

    // youngest matching record wins, x0 never matches
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            fwd_val[i] = rf_val[i];
            hazard[i] = 1'b0;
            if (src[i] != '0) begin
                if (fw_exe.valid && fw_exe.addr == src[i]) begin
                    fwd_val[i] = fw_exe.wdata;
                    hazard[i] = !fw_exe.can_forward;
                end else if (fw_mem.valid && fw_mem.addr == src[i]) begin
                    fwd_val[i] = fw_mem.wdata;
                    hazard[i] = !fw_mem.can_forward;
                end else if (fw_wb.valid && fw_wb.addr == src[i]) begin
                    fwd_val[i] = fw_wb.wdata;
                    hazard[i] = !fw_wb.can_forward;
                end
            end
        end
    end

    assign dh_stall = hazard[0] || hazard[1];

    assign op_a = fwd_val[0];
    assign op_b = ctrl.use_imm ? ctrl.imm : fwd_val[1];
    // stores and branches need rs2 even when op_b is the immediate
    assign store_data = fwd_val[1];

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module decode_stage (
    input  logic [`CORE_XLEN-1:0] inst,
    output core_pkg::ctrl_t       ctrl
);
    import core_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    opcode_e    op;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // classify the encoding first, unknown ones stay illegal
    always_comb begin
        op = OP_ILLEGAL;
        case (inst[6:0])
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = OP_ADD;
                    10'b0100000_000: op = OP_SUB;
                    10'b0000000_111: op = OP_AND;
                    10'b0000000_110: op = OP_OR;
                    10'b0000000_100: op = OP_XOR;
                    default: op = OP_ILLEGAL;
                endcase
            end
            7'b0010011: if (funct3 == 3'b000) op = OP_ADDI;
            7'b0000011: if (funct3 == 3'b010) op = OP_LW;
            7'b0100011: if (funct3 == 3'b010) op = OP_SW;
            7'b1100011: begin
                if (funct3 == 3'b000) op = OP_BEQ;
                else if (funct3 == 3'b001) op = OP_BNE;
            end
            7'b1101111: op = OP_JAL;
            7'b1110011: if (inst == 32'h0000_0073) op = OP_ECALL;
            default: op = OP_ILLEGAL;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.opcode = op;
        ctrl.alu_op = ALU_PASS_B;
        ctrl.wb_sel = WB_NONE;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                ctrl.rs1 = inst[19:15];
                ctrl.rs2 = inst[24:20];
                ctrl.wb_sel = WB_ALU;
            end
            OP_ADDI, OP_LW: begin
                ctrl.rs1 = inst[19:15];
                ctrl.use_imm = 1'b1;
                ctrl.imm = {{20{inst[31]}}, inst[31:20]};
                ctrl.mem_rd = (op == OP_LW);
                ctrl.wb_sel = (op == OP_LW) ? WB_MEM : WB_ALU;
            end
            OP_SW: begin
                ctrl.rs1 = inst[19:15];
                ctrl.rs2 = inst[24:20];
                ctrl.use_imm = 1'b1;
                ctrl.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                ctrl.mem_wr = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.rs1 = inst[19:15];
                ctrl.rs2 = inst[24:20];
                ctrl.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                ctrl.is_branch = 1'b1;
            end
            OP_JAL: begin
                ctrl.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                ctrl.is_jal = 1'b1;
                ctrl.wb_sel = WB_PC4;
            end
            OP_ECALL: ctrl.is_exit = 1'b1;
            default: ;
        endcase
        case (op)
            OP_SUB: ctrl.alu_op = ALU_SUB;
            OP_AND: ctrl.alu_op = ALU_AND;
            OP_OR: ctrl.alu_op = ALU_OR;
            OP_XOR: ctrl.alu_op = ALU_XOR;
            OP_ADD, OP_ADDI, OP_LW, OP_SW: ctrl.alu_op = ALU_ADD;
            default: ;
        endcase
        // writes to x0 are dropped at decode
        if (ctrl.wb_sel != WB_NONE && inst[11:7] != 5'd0) begin
            ctrl.rf_wen = 1'b1;
            ctrl.rd = inst[11:7];
        end
    end

endmodule

/* verilog/fwd_if.sv */
`timescale 1ns/1ns
`include "core_params.svh"

// result record of a later stage as seen by data select
interface fwd_if;
    logic                           valid;
    logic                           can_forward;
    logic [$clog2(`CORE_NREGS)-1:0] addr;
    logic [`CORE_XLEN-1:0]          wdata;

    modport source (output valid, can_forward, addr, wdata);
    modport sink (input valid, can_forward, addr, wdata);
endinterface

/* verilog/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

    // supported instructions where anything else decodes as illegal
    typedef enum logic [3:0] {
        OP_ILLEGAL,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_ADDI, OP_LW, OP_SW,
        OP_BEQ, OP_BNE, OP_JAL,
        OP_ECALL
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
    } alu_op_e;

    // register write source
    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4, WB_NONE
    } wb_sel_e;

    typedef struct packed {
        opcode_e                        opcode;
        alu_op_e                        alu_op;
        wb_sel_e                        wb_sel;
        logic                           rf_wen;
        logic [$clog2(`CORE_NREGS)-1:0] rd;
        logic [$clog2(`CORE_NREGS)-1:0] rs1;
        logic [$clog2(`CORE_NREGS)-1:0] rs2;
        logic                           use_imm;
        logic [`CORE_XLEN-1:0]          imm;
        logic                           mem_rd;
        logic                           mem_wr;
        logic                           is_branch;
        logic                           is_jal;
        logic                           is_exit;
    } ctrl_t;

endpackage

/* verilog/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define CORE_XLEN 32

// architectural registers, x0 included
`define CORE_NREGS 32

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif
